//--- sim.f
+incdir+verif
source/periph_pkg.sv
source/periph_timer.sv
source/pwm_modulator.sv
source/gpio_pin_mux.sv
source/periph_reg_file.sv
source/peripheral_unit.sv
verif/tb_peripheral_unit.sv

//--- Makefile
TOP = tb_peripheral_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Register map seen from the core
localparam logic [31:0] ADDR_BASE        = 32'h1000_0000;
localparam logic [31:0] ADDR_TIM_CTRL    = ADDR_BASE + 32'h00;
localparam logic [31:0] ADDR_TIM_CMP_L   = ADDR_BASE + 32'h04;
localparam logic [31:0] ADDR_TIM_CNT_L   = ADDR_BASE + 32'h0C;
localparam logic [31:0] ADDR_PWM_EN      = ADDR_BASE + 32'h14;
localparam logic [31:0] ADDR_PWM_DIV     = ADDR_BASE + 32'h18;
localparam logic [31:0] ADDR_PWM_DUTY    = ADDR_BASE + 32'h1C;
localparam logic [31:0] ADDR_GPIO_OUT    = ADDR_BASE + 32'h20;
localparam logic [31:0] ADDR_GPIO_IN     = ADDR_BASE + 32'h24;
localparam logic [31:0] ADDR_GPIO_OE     = ADDR_BASE + 32'h28;
localparam logic [31:0] ADDR_GPIO_SEL    = ADDR_BASE + 32'h2C;
localparam logic [31:0] ADDR_GPIO_IRQEN  = ADDR_BASE + 32'h30;
localparam logic [31:0] ADDR_GPIO_IRQPOL = ADDR_BASE + 32'h34;
localparam logic [31:0] ADDR_GPIO_IRQ    = ADDR_BASE + 32'h38;

// Cycles to wait for o_rvalid
localparam int RSP_LIMIT = 4;

// Called on a falling edge, returns on the falling edge that shows o_rvalid
task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] be, output logic [31:0] rdata);
   int waited;
   waited  = 0;
   i_req   = 1'b1;
   i_we    = we;
   i_addr  = addr;
   i_wdata = wdata;
   i_be    = be;
   @(negedge i_clk);
   i_req = 1'b0;
   i_we  = 1'b0;
   while (!o_rvalid && waited < RSP_LIMIT) begin
      @(negedge i_clk);
      waited++;
   end
   if (!o_rvalid) begin
      err_timeout++;
      $display("%0t: no response to the bus request at address %08h", $time, addr);
   end
   rdata = o_rdata;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] be);
   logic [31:0] ignored;
   bus_access(1'b1, addr, wdata, be, ignored);
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
   bus_access(1'b0, addr, 32'h0, 4'hf, rdata);
endtask

`endif

//--- verif/tb_peripheral_unit.sv
`timescale 1ns/1ps

module tb_peripheral_unit;

   localparam int CLK_PERIOD = 8;
   // PWM at div 3 twice, the longest timer compare, bus traffic
   localparam int TEST_CYCLES     = 2 * 256 * 4 + 220 + 1000;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES * 8;

   logic        i_clk;
   logic        i_rst_n;
   logic        i_req;
   logic        i_we;
   logic [31:0] i_addr;
   logic [31:0] i_wdata;
   logic [3:0]  i_be;
   logic [15:0] i_io_in;
   logic        o_gnt;
   logic        o_rvalid;
   logic [31:0] o_rdata;
   logic        o_timer_irq;
   logic        o_gpio_irq;
   logic [15:0] o_io_out;
   logic [15:0] o_io_oe_n;
   logic        rvalid_exp;
   int          err_proto;
   int          err_data;
   int          err_timeout;

   `include "tb_bus_tasks.svh"

   peripheral_unit i_dut (.*);

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   //////////////////////////////
   // Bus protocol
   //////////////////////////////

   // Each request is answered in the next cycle
   always @(posedge i_clk) begin
      rvalid_exp <= i_req;
   end

   assert property (@(posedge i_clk) o_gnt == i_req)
      else begin
         err_proto++;
         $display("[ERROR] %0t o_gnt: got %0b, expected %0b", $time, $sampled(o_gnt),
                  $sampled(i_req));
      end

   assert property (@(posedge i_clk) disable iff (!i_rst_n) o_rvalid == rvalid_exp)
      else begin
         err_proto++;
         $display("[ERROR] %0t o_rvalid: got %0b, expected %0b", $time, $sampled(o_rvalid),
                  $sampled(rvalid_exp));
      end

   // Write responses carry no data
   assert property (@(posedge i_clk) disable iff (!i_rst_n)
                    ($past(i_req) && $past(i_we)) |-> o_rdata == '0)
      else begin
         err_proto++;
         $display("[ERROR] %0t o_rdata: got %08h, expected 00000000", $time, $sampled(o_rdata));
      end

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp)
         else begin
            err_data++;
            $display("[ERROR] %0t %s: got %08h, expected %08h", $time, name, got, exp);
         end
   endtask

   function automatic logic [31:0] zero_extend_pins(input logic [15:0] p);
      return {16'h0, p};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_v,
                                               input logic [31:0] new_v, input logic [3:0] be);
      logic [31:0] res;
      res = old_v;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = new_v[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Model starts from the reset value 0
   task automatic test_byte_merge(input string name, input logic [31:0] addr,
                                  input logic [31:0] mask);
      logic [31:0] model;
      logic [31:0] wdata;
      logic [31:0] rdata;
      logic [3:0]  be;
      model = '0;
      repeat (4) begin
         wdata = $urandom;
         be    = 4'($urandom);
         model = merge_bytes(model, wdata, be) & mask;
         bus_write(addr, wdata, be);
         bus_read(addr, rdata);
         expect_equal(name, rdata, model);
      end
   endtask

   task automatic wait_irq_level(input bit timer, input logic level, input int limit);
      int    waited;
      string name;
      waited = 0;
      if (timer) begin
         name = "timer";
      end else begin
         name = "GPIO";
      end
      while ((timer ? o_timer_irq : o_gpio_irq) !== level && waited < limit) begin
         @(negedge i_clk);
         waited++;
      end
      if ((timer ? o_timer_irq : o_gpio_irq) !== level) begin
         err_timeout++;
         $display("%0t: %s interrupt did not go to %0b within %0d cycles", $time,
                  name, level, limit);
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Verification failed");
      $finish;
   end

   initial begin
      logic [31:0] rd;
      logic [31:0] cmp;
      logic [15:0] pins;
      logic [15:0] oe;
      logic [15:0] sel;
      logic        pol;
      int          pin;
      int          duty;
      int          div;
      int          period;
      int          highs;
      i_clk       = 1'b0;
      i_rst_n     = 1'b0;
      i_req       = 1'b0;
      i_we        = 1'b0;
      i_addr      = '0;
      i_wdata     = '0;
      i_be        = '0;
      i_io_in     = '0;
      err_proto   = 0;
      err_data    = 0;
      err_timeout = 0;
      void'($urandom(32'hcd974b43));
      repeat (16) @(posedge i_clk);
      expect_equal("o_rvalid", {31'h0, o_rvalid}, 32'h0);
      expect_equal("o_timer_irq", {31'h0, o_timer_irq}, 32'h0);
      expect_equal("o_gpio_irq", {31'h0, o_gpio_irq}, 32'h0);
      expect_equal("o_io_out", zero_extend_pins(o_io_out), 32'h0);
      expect_equal("o_io_oe_n", zero_extend_pins(o_io_oe_n), 32'h0000_ffff);
      @(negedge i_clk);
      i_rst_n = 1'b1;

      test_byte_merge("o_rdata TIM_CMP_L", ADDR_TIM_CMP_L, 32'hffff_ffff);
      test_byte_merge("o_rdata PWM_DIV", ADDR_PWM_DIV, 32'h0000_00ff);
      test_byte_merge("o_rdata GPIO_OUT", ADDR_GPIO_OUT, 32'h0000_ffff);

      //////////////////////////////
      // Timer
      //////////////////////////////
      cmp = 20 + ($urandom % 181);
      bus_write(ADDR_TIM_CMP_L, cmp, 4'hf);
      bus_write(ADDR_TIM_CTRL, 32'h1, 4'hf);
      wait_irq_level(1'b1, 1'b1, 250);
      bus_read(ADDR_TIM_CNT_L, rd);
      assert (rd >= cmp)
         else begin
            err_data++;
            $display("[ERROR] %0t TIM_CNT_L: got %0d, expected at least %0d", $time, rd, cmp);
         end
      // Enable with the clear strobe
      bus_write(ADDR_TIM_CTRL, 32'h3, 4'hf);
      wait_irq_level(1'b1, 1'b0, 2);
      bus_read(ADDR_TIM_CNT_L, rd);
      assert (rd < cmp)
         else begin
            err_data++;
            $display("[ERROR] %0t TIM_CNT_L: got %0d, expected below %0d", $time, rd, cmp);
         end
      bus_write(ADDR_TIM_CTRL, 32'h0, 4'hf);

      //////////////////////////////
      // PWM on pin 0
      //////////////////////////////
      duty   = $urandom % 256;
      div    = $urandom % 4;
      period = 256 * (div + 1);
      bus_write(ADDR_PWM_DIV, div, 4'hf);
      bus_write(ADDR_PWM_DUTY, duty, 4'hf);
      bus_write(ADDR_GPIO_SEL, 32'h1, 4'hf);
      bus_write(ADDR_PWM_EN, 32'h1, 4'hf);
      repeat (period) @(negedge i_clk);
      highs = 0;
      repeat (period) begin
         if (o_io_out[0]) begin
            highs++;
         end
         @(negedge i_clk);
      end
      expect_equal("o_io_out[0] high cycles", highs, duty * (div + 1));
      bus_write(ADDR_PWM_EN, 32'h0, 4'hf);

      //////////////////////////////
      // GPIO
      //////////////////////////////
      pins = 16'($urandom);
      oe   = 16'($urandom);
      bus_write(ADDR_GPIO_SEL, 32'h0, 4'hf);
      bus_write(ADDR_GPIO_OUT, zero_extend_pins(pins), 4'hf);
      bus_write(ADDR_GPIO_OE, zero_extend_pins(oe), 4'hf);
      expect_equal("o_io_out", zero_extend_pins(o_io_out), zero_extend_pins(pins));
      expect_equal("o_io_oe_n", zero_extend_pins(o_io_oe_n), zero_extend_pins(~oe));
      sel = 16'($urandom);
      bus_write(ADDR_GPIO_SEL, zero_extend_pins(sel), 4'hf);
      expect_equal("o_io_oe_n", zero_extend_pins(o_io_oe_n & sel), 32'h0);
      // PWM is off, so selected pins drive low
      expect_equal("o_io_out", zero_extend_pins(o_io_out), zero_extend_pins(pins & ~sel));
      bus_write(ADDR_GPIO_SEL, 32'h0, 4'hf);

      pins    = 16'($urandom);
      i_io_in = pins;
      repeat (3) @(negedge i_clk);
      bus_read(ADDR_GPIO_IN, rd);
      expect_equal("o_rdata GPIO_IN", rd, zero_extend_pins(pins));

      repeat (3) begin
         pin = $urandom % 16;
         pol = 1'($urandom);
         bus_write(ADDR_GPIO_IRQEN, 32'h0, 4'hf);
         i_io_in[pin] = ~pol;
         repeat (4) @(negedge i_clk);
         bus_write(ADDR_GPIO_IRQPOL, {31'h0, pol} << pin, 4'hf);
         bus_write(ADDR_GPIO_IRQEN, 32'h1 << pin, 4'hf);
         // Edge toward the polarity
         i_io_in[pin] = pol;
         wait_irq_level(1'b0, 1'b1, 4);
         bus_read(ADDR_GPIO_IRQ, rd);
         expect_equal("o_rdata GPIO_IRQ", rd, 32'h1 << pin);
         bus_write(ADDR_GPIO_IRQ, 32'h1 << pin, 4'hf);
         wait_irq_level(1'b0, 1'b0, 2);
         i_io_in[pin] = ~pol;
         repeat (4) @(negedge i_clk);
         expect_equal("o_gpio_irq", {31'h0, o_gpio_irq}, 32'h0);
         bus_read(ADDR_GPIO_IRQ, rd);
         expect_equal("o_rdata GPIO_IRQ", rd, 32'h0);
      end
      bus_write(ADDR_GPIO_IRQEN, 32'h0, 4'hf);

      repeat (4) @(negedge i_clk);
      $display("Errors: protocol %0d, data %0d, timeout %0d", err_proto, err_data, err_timeout);
      if (err_proto + err_data + err_timeout == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- source/peripheral_unit.sv
`timescale 1ns/1ps

module peripheral_unit #(
   parameter periph_pkg::data_t BASE_ADDR = 32'h1000_0000
) (
   input  logic              i_clk,
   input  logic              i_rst_n,
   // Core bus
   input  logic              i_req,
   input  logic              i_we,
   input  periph_pkg::data_t i_addr,
   input  periph_pkg::data_t i_wdata,
   input  periph_pkg::be_t   i_be,
   output logic              o_gnt,
   output logic              o_rvalid,
   output periph_pkg::data_t o_rdata,
   // Interrupts
   output logic              o_timer_irq,
   output logic              o_gpio_irq,
   // Pins
   input  periph_pkg::pins_t i_io_in,
   output periph_pkg::pins_t o_io_out,
   output periph_pkg::pins_t o_io_oe_n
);

   periph_pkg::bus_req_t  bus_req;
   periph_pkg::tim_cfg_t  tim_cfg;
   periph_pkg::pwm_cfg_t  pwm_cfg;
   periph_pkg::gpio_cfg_t gpio_cfg;
   periph_pkg::tick_t     tim_count;
   periph_pkg::pins_t     irq_clr;
   periph_pkg::pins_t     gpio_in;
   periph_pkg::pins_t     irq_pend;
   logic                  pwm_out;

   assign bus_req = '{we: i_we, addr: i_addr, wdata: i_wdata, be: i_be};

   periph_reg_file #(
      .BASE_ADDR(BASE_ADDR)
   ) u_reg_file (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_req),
      .i_bus      (bus_req),
      .o_gnt      (o_gnt),
      .o_rvalid   (o_rvalid),
      .o_rdata    (o_rdata),
      .o_tim_cfg  (tim_cfg),
      .i_tim_count(tim_count),
      .o_pwm_cfg  (pwm_cfg),
      .o_gpio_cfg (gpio_cfg),
      .o_irq_clr  (irq_clr),
      .i_gpio_in  (gpio_in),
      .i_irq_pend (irq_pend)
   );

   periph_timer u_timer (
      .i_clk  (i_clk),
      .i_rst_n(i_rst_n),
      .i_cfg  (tim_cfg),
      .o_count(tim_count),
      .o_irq  (o_timer_irq)
   );

   pwm_modulator u_pwm (
      .i_clk  (i_clk),
      .i_rst_n(i_rst_n),
      .i_cfg  (pwm_cfg),
      .o_pwm  (pwm_out)
   );

   gpio_pin_mux u_pin_mux (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_cfg     (gpio_cfg),
      .i_irq_clr (irq_clr),
      .i_pwm     (pwm_out),
      .i_io_in   (i_io_in),
      .o_io_out  (o_io_out),
      .o_io_oe_n (o_io_oe_n),
      .o_gpio_in (gpio_in),
      .o_irq_pend(irq_pend),
      .o_irq     (o_gpio_irq)
   );

endmodule

//--- source/periph_reg_file.sv
`timescale 1ns/1ps

module periph_reg_file #(
   parameter periph_pkg::data_t BASE_ADDR = 32'h1000_0000
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_req,
   input  periph_pkg::bus_req_t  i_bus,
   output logic                  o_gnt,
   output logic                  o_rvalid,
   output periph_pkg::data_t     o_rdata,
   output periph_pkg::tim_cfg_t  o_tim_cfg,
   input  periph_pkg::tick_t     i_tim_count,
   output periph_pkg::pwm_cfg_t  o_pwm_cfg,
   output periph_pkg::gpio_cfg_t o_gpio_cfg,
   output periph_pkg::pins_t     o_irq_clr,
   input  periph_pkg::pins_t     i_gpio_in,
   input  periph_pkg::pins_t     i_irq_pend
);

   periph_pkg::data_t     offset;
   periph_pkg::data_t     be_mask;
   periph_pkg::data_t     rd_word;
   periph_pkg::data_t     wr_word;
   logic                  wr_en;

   periph_pkg::tim_cfg_t  tim_cfg_q;
   periph_pkg::pwm_cfg_t  pwm_cfg_q;
   periph_pkg::gpio_cfg_t gpio_cfg_q;
   periph_pkg::pins_t     irq_clr_q;

   // No wait states
   assign o_gnt = i_req;
   assign wr_en = i_req & i_bus.we;

   //////////////////////////////
   // Decode and read mux
   //////////////////////////////

   always_comb begin
      offset = i_bus.addr - BASE_ADDR;
      for (int b = 0; b < 4; b++) begin
         be_mask[8*b +: 8] = {8{i_bus.be[b]}};
      end
      case (offset)
         periph_pkg::TIM_CTRL_OFS:    rd_word = periph_pkg::data_t'(tim_cfg_q.en);
         periph_pkg::TIM_CMP_L_OFS:   rd_word = tim_cfg_q.cmp[31:0];
         periph_pkg::TIM_CMP_H_OFS:   rd_word = tim_cfg_q.cmp[63:32];
         periph_pkg::TIM_CNT_L_OFS:   rd_word = i_tim_count[31:0];
         periph_pkg::TIM_CNT_H_OFS:   rd_word = i_tim_count[63:32];
         periph_pkg::PWM_EN_OFS:      rd_word = periph_pkg::data_t'(pwm_cfg_q.en);
         periph_pkg::PWM_DIV_OFS:     rd_word = periph_pkg::data_t'(pwm_cfg_q.div);
         periph_pkg::PWM_DUTY_OFS:    rd_word = periph_pkg::data_t'(pwm_cfg_q.duty);
         periph_pkg::GPIO_OUT_OFS:    rd_word = periph_pkg::data_t'(gpio_cfg_q.out);
         periph_pkg::GPIO_IN_OFS:     rd_word = periph_pkg::data_t'(i_gpio_in);
         periph_pkg::GPIO_OE_OFS:     rd_word = periph_pkg::data_t'(gpio_cfg_q.oe);
         periph_pkg::GPIO_SEL_OFS:    rd_word = periph_pkg::data_t'(gpio_cfg_q.sel);
         periph_pkg::GPIO_IRQEN_OFS:  rd_word = periph_pkg::data_t'(gpio_cfg_q.irq_en);
         periph_pkg::GPIO_IRQPOL_OFS: rd_word = periph_pkg::data_t'(gpio_cfg_q.irq_pol);
         periph_pkg::GPIO_IRQ_OFS:    rd_word = periph_pkg::data_t'(i_irq_pend);
         default:                     rd_word = '0;
      endcase
      // Old value with the enabled bytes replaced
      wr_word = (rd_word & ~be_mask) | (i_bus.wdata & be_mask);
   end

   //////////////////////////////
   // Control registers
   //////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         tim_cfg_q  <= '0;
         pwm_cfg_q  <= '0;
         gpio_cfg_q <= '0;
         irq_clr_q  <= '0;
      end else begin
         // Strobes last one cycle
         tim_cfg_q.clr <= 1'b0;
         irq_clr_q     <= '0;
         if (wr_en) begin
            case (offset)
               periph_pkg::TIM_CTRL_OFS: begin
                  tim_cfg_q.en  <= wr_word[0];
                  tim_cfg_q.clr <= wr_word[1];
               end
               periph_pkg::TIM_CMP_L_OFS:   tim_cfg_q.cmp[31:0]  <= wr_word;
               periph_pkg::TIM_CMP_H_OFS:   tim_cfg_q.cmp[63:32] <= wr_word;
               periph_pkg::PWM_EN_OFS:      pwm_cfg_q.en         <= wr_word[0];
               periph_pkg::PWM_DIV_OFS:     pwm_cfg_q.div        <= wr_word[7:0];
               periph_pkg::PWM_DUTY_OFS:    pwm_cfg_q.duty       <= wr_word[7:0];
               periph_pkg::GPIO_OUT_OFS: begin
                  gpio_cfg_q.out <= wr_word[periph_pkg::PIN_COUNT-1:0];
               end
               periph_pkg::GPIO_OE_OFS: begin
                  gpio_cfg_q.oe <= wr_word[periph_pkg::PIN_COUNT-1:0];
               end
               periph_pkg::GPIO_SEL_OFS: begin
                  gpio_cfg_q.sel <= wr_word[periph_pkg::PIN_COUNT-1:0];
               end
               periph_pkg::GPIO_IRQEN_OFS: begin
                  gpio_cfg_q.irq_en <= wr_word[periph_pkg::PIN_COUNT-1:0];
               end
               periph_pkg::GPIO_IRQPOL_OFS: begin
                  gpio_cfg_q.irq_pol <= wr_word[periph_pkg::PIN_COUNT-1:0];
               end
               periph_pkg::GPIO_IRQ_OFS: begin
                  // Write 1 to clear, only in enabled bytes
                  irq_clr_q <= i_bus.wdata[periph_pkg::PIN_COUNT-1:0]
                               & be_mask[periph_pkg::PIN_COUNT-1:0];
               end
               default: ;
            endcase
         end
      end
   end

   // Response one cycle after each granted request
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rvalid <= 1'b0;
         o_rdata  <= '0;
      end else begin
         o_rvalid <= i_req;
         o_rdata  <= (i_req && !i_bus.we) ? rd_word : '0;
      end
   end

   assign o_tim_cfg  = tim_cfg_q;
   assign o_pwm_cfg  = pwm_cfg_q;
   assign o_gpio_cfg = gpio_cfg_q;
   assign o_irq_clr  = irq_clr_q;

endmodule

//--- source/gpio_pin_mux.sv
`timescale 1ns/1ps

module gpio_pin_mux (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  periph_pkg::gpio_cfg_t i_cfg,
   input  periph_pkg::pins_t     i_irq_clr,
   input  logic                  i_pwm,
   input  periph_pkg::pins_t     i_io_in,
   output periph_pkg::pins_t     o_io_out,
   output periph_pkg::pins_t     o_io_oe_n,
   output periph_pkg::pins_t     o_gpio_in,
   output periph_pkg::pins_t     o_irq_pend,
   output logic                  o_irq
);

   periph_pkg::pins_t sync_1;
   periph_pkg::pins_t sync_2;
   periph_pkg::pins_t prev;
   periph_pkg::pins_t rise;
   periph_pkg::pins_t fall;
   periph_pkg::pins_t edge_hit;
   periph_pkg::pins_t pend_q;
   periph_pkg::pins_t pend_nxt;
   logic              irq_q;

   //////////////////////////////
   // Output path
   //////////////////////////////

   // sel 1 routes PWM and forces the driver on
   assign o_io_out  = (i_cfg.sel & {periph_pkg::PIN_COUNT{i_pwm}}) | (~i_cfg.sel & i_cfg.out);
   assign o_io_oe_n = ~(i_cfg.oe | i_cfg.sel);

   //////////////////////////////
   // Input path
   //////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sync_1 <= '0;
         sync_2 <= '0;
         prev   <= '0;
      end else begin
         sync_1 <= i_io_in;
         sync_2 <= sync_1;
         prev   <= sync_2;
      end
   end

   assign o_gpio_in = sync_2;

   // Edge toward irq_pol on enabled pins
   always_comb begin
      rise     = sync_2 & ~prev;
      fall     = ~sync_2 & prev;
      edge_hit = ((i_cfg.irq_pol & rise) | (~i_cfg.irq_pol & fall)) & i_cfg.irq_en;
      // Set beats clear
      pend_nxt = (pend_q & ~i_irq_clr) | edge_hit;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pend_q <= '0;
         irq_q  <= 1'b0;
      end else begin
         pend_q <= pend_nxt;
         irq_q  <= |pend_nxt;
      end
   end

   assign o_irq_pend = pend_q;
   assign o_irq      = irq_q;

endmodule

//--- source/pwm_modulator.sv
`timescale 1ns/1ps

module pwm_modulator (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  periph_pkg::pwm_cfg_t i_cfg,
   output logic                 o_pwm
);

   periph_pkg::duty_t pre_cnt;
   periph_pkg::duty_t phase;
   logic              tick;
   logic              pwm_q;

   // One tick every div+1 clocks
   assign tick = (pre_cnt >= i_cfg.div);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pre_cnt <= '0;
      end else if (!i_cfg.en) begin
         pre_cnt <= '0;
      end else if (tick) begin
         pre_cnt <= '0;
      end else begin
         pre_cnt <= pre_cnt + 8'd1;
      end
   end

   // Phase wraps at 256
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase <= '0;
      end else if (!i_cfg.en) begin
         phase <= '0;
      end else if (tick) begin
         phase <= phase + 8'd1;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pwm_q <= 1'b0;
      end else begin
         pwm_q <= i_cfg.en && (phase < i_cfg.duty);
      end
   end

   assign o_pwm = pwm_q;

endmodule

//--- source/periph_timer.sv
`timescale 1ns/1ps

module periph_timer (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  periph_pkg::tim_cfg_t i_cfg,
   output periph_pkg::tick_t    o_count,
   output logic                 o_irq
);

   periph_pkg::tick_t count_q;
   periph_pkg::tick_t count_nxt;
   logic              irq_q;

   // Clear wins over counting
   always_comb begin
      if (i_cfg.clr) begin
         count_nxt = '0;
      end else if (i_cfg.en) begin
         count_nxt = count_q + 64'd1;
      end else begin
         count_nxt = count_q;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         count_q <= '0;
      end else begin
         count_q <= count_nxt;
      end
   end

   // Compare on next count so irq tracks the counter register
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         irq_q <= 1'b0;
      end else begin
         irq_q <= i_cfg.en && (count_nxt >= i_cfg.cmp);
      end
   end

   assign o_count = count_q;
   assign o_irq   = irq_q;

endmodule

//--- source/periph_pkg.sv
package periph_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int PIN_COUNT = 16;

   // Bus word, also used for addresses
   typedef logic [31:0]          data_t;
   typedef logic [3:0]           be_t;
   typedef logic [PIN_COUNT-1:0] pins_t;
   typedef logic [7:0]           duty_t;
   typedef logic [63:0]          tick_t;

   //////////////////////////////
   // Register offsets
   //////////////////////////////

   localparam data_t TIM_CTRL_OFS    = 32'h00;
   localparam data_t TIM_CMP_L_OFS   = 32'h04;
   localparam data_t TIM_CMP_H_OFS   = 32'h08;
   localparam data_t TIM_CNT_L_OFS   = 32'h0C;
   localparam data_t TIM_CNT_H_OFS   = 32'h10;
   localparam data_t PWM_EN_OFS      = 32'h14;
   localparam data_t PWM_DIV_OFS     = 32'h18;
   localparam data_t PWM_DUTY_OFS    = 32'h1C;
   localparam data_t GPIO_OUT_OFS    = 32'h20;
   localparam data_t GPIO_IN_OFS     = 32'h24;
   localparam data_t GPIO_OE_OFS     = 32'h28;
   localparam data_t GPIO_SEL_OFS    = 32'h2C;
   localparam data_t GPIO_IRQEN_OFS  = 32'h30;
   localparam data_t GPIO_IRQPOL_OFS = 32'h34;
   localparam data_t GPIO_IRQ_OFS    = 32'h38;

   //////////////////////////////
   // Bus and configuration
   //////////////////////////////

   typedef struct packed {
      logic  we;
      data_t addr;
      data_t wdata;
      be_t   be;
   } bus_req_t;

   typedef struct packed {
      logic  en;
      logic  clr;
      tick_t cmp;
   } tim_cfg_t;

   typedef struct packed {
      logic  en;
      duty_t div;
      duty_t duty;
   } pwm_cfg_t;

   // Per-pin control, bit n belongs to pin n
   typedef struct packed {
      pins_t out;
      pins_t oe;
      pins_t sel;
      pins_t irq_en;
      pins_t irq_pol;
   } gpio_cfg_t;

endpackage
